/* Makefile */
# Verilator build and run for the dot-product unit

VERILATOR ?= verilator
TOP       ?= dot_product_tb
FILELIST  ?= dot_product_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/dot_cfg_pkg.sv */
// Data-path constants for the dot-product unit
// Lane count, product count, pipeline depth and default data width

package dot_cfg_pkg;

   // Operand words per vector, sent as a0, b0, a1, b1, ...
   localparam int LANES = 8;

   // One product per a/b pair
   localparam int PAIRS = LANES / 2;

   // Register, multiply, first adder level, final adder
   localparam int PIPE_LATENCY = 4;

   // Default for the WIDTH parameter
   // Products and sums wrap at this width
   localparam int DEFAULT_WIDTH = 16;

endpackage

/* design/dot_ctrl_pkg.sv */
// Control types for the dot-product unit
// Loader handshake state and default result queue depth

package dot_ctrl_pkg;

   // Receiving side of the input four-phase channel
   // WAIT_SLOT holds off the eighth word until the queue has room
   typedef enum logic [1:0] {
      IDLE,
      ACK_HIGH,
      WAIT_SLOT
   } loader_state_t;

   // Result slots, counting stored and in-flight vectors
   localparam int DEFAULT_DEPTH = 4;

endpackage

/* design/dot_product_top.sv */
// Dot-product unit top level
// Loader, multiply/adder pipeline and result queue

`timescale 1ns/1ps

module dot_product_top #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH,
   parameter int DEPTH = dot_ctrl_pkg::DEFAULT_DEPTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_req,
   input  logic [WIDTH-1:0] in_data,
   output logic             in_ack,
   output logic             out_req,
   output logic [WIDTH-1:0] out_data,
   input  logic             out_ack
);
   import dot_cfg_pkg::*;

   // Issued vector, seen by the pipeline and the queue
   logic [WIDTH-1:0] vec_data [LANES];
   logic             vec_valid;
   logic             slot_free;
   // Pipeline result
   logic [WIDTH-1:0] sum;
   logic             sum_valid;

   operand_loader #(.WIDTH(WIDTH)) u_loader (
      .clk       (clk),
      .rst       (rst),
      .in_req    (in_req),
      .in_data   (in_data),
      .in_ack    (in_ack),
      .slot_free (slot_free),
      .vec_data  (vec_data),
      .vec_valid (vec_valid)
   );

   mac_tree_pipeline #(.WIDTH(WIDTH)) u_pipe (
      .clk       (clk),
      .rst       (rst),
      .vec_data  (vec_data),
      .vec_valid (vec_valid),
      .sum       (sum),
      .sum_valid (sum_valid)
   );

   result_queue #(.WIDTH(WIDTH), .DEPTH(DEPTH)) u_queue (
      .clk       (clk),
      .rst       (rst),
      .vec_valid (vec_valid),
      .sum       (sum),
      .sum_valid (sum_valid),
      .slot_free (slot_free),
      .out_req   (out_req),
      .out_data  (out_data),
      .out_ack   (out_ack)
   );

endmodule

/* design/mac_tree_pipeline.sv */
// Multiply and adder-tree pipeline
// Four registered stages with a matching valid delay line

`timescale 1ns/1ps

module mac_tree_pipeline #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic [WIDTH-1:0] vec_data [dot_cfg_pkg::LANES],
   input  logic             vec_valid,
   output logic [WIDTH-1:0] sum,
   output logic             sum_valid
);
   import dot_cfg_pkg::*;

   logic [WIDTH-1:0]        in_r   [LANES];
   logic [WIDTH-1:0]        prod_r [PAIRS];
   logic [WIDTH-1:0]        part_r [PAIRS/2];
   logic [WIDTH-1:0]        sum_r;
   logic [PIPE_LATENCY-1:0] valid_dly;

   // ==========================================================================
   // Data path
   // ==========================================================================
   // Every stage truncates to WIDTH bits, so the result wraps
   always_ff @(posedge clk) begin
      // Stage 1: capture the vector
      for (int i = 0; i < LANES; i++) begin
         in_r[i] <= vec_data[i];
      end
      // Stage 2: a*b for each pair
      for (int i = 0; i < PAIRS; i++) begin
         prod_r[i] <= in_r[2*i] * in_r[2*i+1];
      end
      // Stage 3: first adder level
      for (int i = 0; i < PAIRS/2; i++) begin
         part_r[i] <= prod_r[2*i] + prod_r[2*i+1];
      end
      // Stage 4: final adder
      sum_r <= part_r[0] + part_r[1];
   end

   // ==========================================================================
   // Valid delay line
   // ==========================================================================
   // One bit per stage, so a new vector may enter every cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         valid_dly <= '0;
      end else begin
         valid_dly <= {valid_dly[PIPE_LATENCY-2:0], vec_valid};
      end
   end

   assign sum       = sum_r;
   assign sum_valid = valid_dly[PIPE_LATENCY-1];

endmodule

/* design/operand_loader.sv */
// Operand loader
// Four-phase receiver that gathers eight words and issues one vector

`timescale 1ns/1ps

module operand_loader #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_req,
   input  logic [WIDTH-1:0] in_data,
   output logic             in_ack,
   input  logic             slot_free,
   output logic [WIDTH-1:0] vec_data [dot_cfg_pkg::LANES],
   output logic             vec_valid
);
   import dot_cfg_pkg::*;
   import dot_ctrl_pkg::*;

   localparam int CNT_W = $clog2(LANES);
   localparam logic [CNT_W-1:0] LAST_ELEM = CNT_W'(LANES - 1);

   loader_state_t    state;
   logic [CNT_W-1:0] elem_cnt;
   logic             is_last;
   logic             accept;

   // Eighth word of the vector is pending
   assign is_last = (elem_cnt == LAST_ELEM);

   // Word taken this cycle
   // the last word only goes in when the queue can reserve a slot
   assign accept = ((state == IDLE) && in_req && (!is_last || slot_free)) ||
                   ((state == WAIT_SLOT) && slot_free);

   // ==========================================================================
   // Handshake FSM and element counter
   // ==========================================================================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state     <= IDLE;
         in_ack    <= 1'b0;
         vec_valid <= 1'b0;
         elem_cnt  <= '0;
      end else begin
         // Single-cycle issue pulse
         vec_valid <= 1'b0;
         case (state)
            IDLE: begin
               if (accept) begin
                  in_ack <= 1'b1;
                  state  <= ACK_HIGH;
               end else if (in_req) begin
                  // Queue full, keep the host waiting on the eighth word
                  state <= WAIT_SLOT;
               end
            end
            WAIT_SLOT: begin
               if (accept) begin
                  in_ack <= 1'b1;
                  state  <= ACK_HIGH;
               end
            end
            ACK_HIGH: begin
               // Host dropped req, release the channel
               if (!in_req) begin
                  in_ack <= 1'b0;
                  state  <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
         if (accept) begin
            if (is_last) begin
               elem_cnt  <= '0;
               vec_valid <= 1'b1;
            end else begin
               elem_cnt <= elem_cnt + 1'b1;
            end
         end
      end
   end

   // Lane registers, one per element position
   always_ff @(posedge clk) begin
      if (accept) begin
         vec_data[elem_cnt] <= in_data;
      end
   end

endmodule

/* design/result_queue.sv */
// Result queue
// Circular buffer with slot reservation and a four-phase output sender

`timescale 1ns/1ps

module result_queue #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH,
   parameter int DEPTH = dot_ctrl_pkg::DEFAULT_DEPTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             vec_valid,
   input  logic [WIDTH-1:0] sum,
   input  logic             sum_valid,
   output logic             slot_free,
   output logic             out_req,
   output logic [WIDTH-1:0] out_data,
   input  logic             out_ack
);
   import dot_cfg_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int OCC_W = $clog2(DEPTH + 1);
   // A reservation lasts exactly PIPE_LATENCY cycles, so no more than
   // that many can be outstanding
   localparam int RESV_W = $clog2(PIPE_LATENCY + 1);

   logic [WIDTH-1:0]  mem [DEPTH];
   logic [PTR_W-1:0]  wr_ptr;
   logic [PTR_W-1:0]  rd_ptr;
   logic [OCC_W-1:0]  occ_cnt;
   logic [RESV_W-1:0] resv_cnt;
   logic              pop;

   // Pointer advance with wrap for any DEPTH
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      if (int'(p) == DEPTH - 1) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   // Host acknowledged the current head
   assign pop = out_req && out_ack;

   // Room for one more vector, stored plus in flight
   assign slot_free = (int'(occ_cnt) + int'(resv_cnt)) < DEPTH;

   // Head entry, stable until popped
   assign out_data = mem[rd_ptr];

   // ==========================================================================
   // Pointers, counters and output handshake
   // ==========================================================================
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         occ_cnt  <= '0;
         resv_cnt <= '0;
         out_req  <= 1'b0;
      end else begin
         // Results arrive in issue order, so the write side is a plain FIFO
         if (sum_valid) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
         case ({sum_valid, pop})
            2'b10:   occ_cnt <= occ_cnt + 1'b1;
            2'b01:   occ_cnt <= occ_cnt - 1'b1;
            default: occ_cnt <= occ_cnt;
         endcase
         // Reserve on issue, release when the sum lands
         case ({vec_valid, sum_valid})
            2'b10:   resv_cnt <= resv_cnt + 1'b1;
            2'b01:   resv_cnt <= resv_cnt - 1'b1;
            default: resv_cnt <= resv_cnt;
         endcase
         // Sender side
         // raise only with ack low, i.e. the previous transfer finished
         if (pop) begin
            out_req <= 1'b0;
         end else if (!out_req && !out_ack && (occ_cnt != '0)) begin
            out_req <= 1'b1;
         end
      end
   end

   // Result storage
   always_ff @(posedge clk) begin
      if (sum_valid) begin
         mem[wr_ptr] <= sum;
      end
   end

endmodule

/* dot_product_top.f */
design/dot_cfg_pkg.sv
design/dot_ctrl_pkg.sv
design/operand_loader.sv
design/mac_tree_pipeline.sv
design/result_queue.sv
design/dot_product_top.sv
dv/dot_product_monitor.sv
dv/dot_product_chk.sv
dv/dot_product_tb.sv

/* dv/dot_product_chk.sv */
// Protocol and pipeline assertions for dot_product_top
// Attached to every instance of the top level with bind

`timescale 1ns/1ps

module dot_product_chk #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH
) (
   input logic             clk,
   input logic             rst,
   input logic             in_req,
   input logic             in_ack,
   input logic             out_req,
   input logic [WIDTH-1:0] out_data,
   input logic             out_ack,
   input logic             vec_valid,
   input logic             sum_valid
);
   import dot_cfg_pkg::*;

   // Loader only acknowledges a pending request
   a_ack_needs_req : assert property (@(posedge clk) disable iff (rst)
      $rose(in_ack) |-> $past(in_req))
      else $error("in_ack rose without in_req");

   // Sender holds request and data until acknowledged
   a_req_hold : assert property (@(posedge clk) disable iff (rst)
      (out_req && !out_ack) |=> (out_req && $stable(out_data)))
      else $error("out_req or out_data changed before out_ack");

   // Fixed pipeline latency
   a_latency : assert property (@(posedge clk) disable iff (rst)
      sum_valid == $past(vec_valid, PIPE_LATENCY))
      else $error("sum_valid does not follow vec_valid by PIPE_LATENCY");

endmodule

bind dot_product_top dot_product_chk #(.WIDTH(WIDTH)) chk0 (.*);

/* dv/dot_product_monitor.sv */
// Scoreboard for the dot-product unit
// Collects operand words, predicts sums and checks results in order

`timescale 1ns/1ps

module dot_product_monitor #(
   parameter int WIDTH = dot_cfg_pkg::DEFAULT_WIDTH
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             in_ack,
   input  logic [WIDTH-1:0] in_data,
   input  logic             out_req,
   input  logic [WIDTH-1:0] out_data,
   input  logic             out_ack,
   input  logic             ref_push,
   input  logic             ref_has,
   input  logic [WIDTH-1:0] ref_sum,
   input  logic             quiet,
   input  logic             stall,
   input  logic             report,
   output int               checked,
   output int               errors
);
   import dot_cfg_pkg::*;

   logic             ack_q;
   logic [WIDTH-1:0] words [LANES];
   int               nword;
   logic [WIDTH-1:0] exp_q [$];
   logic             has_q [$];
   logic [WIDTH-1:0] ref_q [$];
   logic [WIDTH-1:0] exp_v;
   logic [WIDTH-1:0] ref_v;
   logic             has_v;

   // Sum of a*b over the pairs, every step truncated to WIDTH bits
   function automatic logic [WIDTH-1:0] expected_sum();
      logic [WIDTH-1:0] acc;
      logic [WIDTH-1:0] prod;
      acc = '0;
      for (int i = 0; i < LANES; i += 2) begin
         prod = WIDTH'(words[i] * words[i+1]);
         acc  = acc + prod;
      end
      return acc;
   endfunction

   initial begin
      checked = 0;
      errors  = 0;
      nword   = 0;
   end

   always @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         nword = 0;
      end else begin
         // Table values from the testbench, one per vector
         if (ref_push) begin
            has_q.push_back(ref_has);
            ref_q.push_back(ref_sum);
         end
         // Word accepted on the rising edge of in_ack
         if (in_ack && !ack_q) begin
            words[nword] = in_data;
            nword++;
            if (nword == LANES) begin
               exp_q.push_back(expected_sum());
               nword = 0;
            end
         end
         if (quiet && (in_ack || out_req)) begin
            $display("Error at %0t: handshake activity while the host was idle", $time);
            errors++;
         end
         if (stall && in_ack && !ack_q) begin
            $display("Error at %0t: in_ack rose although the result queue was full", $time);
            errors++;
         end
         // Pop seen on the output channel
         if (out_req && out_ack) begin
            if (exp_q.size() == 0) begin
               $display("Error at %0t: a result came back with no vector issued", $time);
               errors++;
            end else begin
               exp_v = exp_q.pop_front();
               has_v = (has_q.size() != 0) ? has_q.pop_front() : 1'b0;
               ref_v = (ref_q.size() != 0) ? ref_q.pop_front() : '0;
               if (out_data !== exp_v) begin
                  $display("[FAIL] %0t: result %0d got %h, expected %h",
                           $time, checked, out_data, exp_v);
                  errors++;
               end else if (has_v && (out_data !== ref_v)) begin
                  $display("[FAIL] %0t: result %0d got %h, table value %h",
                           $time, checked, out_data, ref_v);
                  errors++;
               end else begin
                  $display("result %0d ok, sum %h", checked, out_data);
               end
               checked++;
            end
         end
         if (report) begin
            $display("Results checked: %0d, errors: %0d", checked, errors);
         end
         ack_q <= in_ack;
      end
   end

endmodule

/* dv/dot_product_tb.sv */
// Testbench for the dot-product unit
// Clock, reset, directed table, back-pressure, LFSR vectors, watchdog

`timescale 1ns/1ps

module dot_product_tb;
   localparam int WIDTH     = 16;
   localparam int DEPTH     = 4;
   localparam int NUM_ROWS  = 8;
   localparam int NUM_RAND  = 16;
   localparam int NUM_TESTS = NUM_ROWS + 1 + NUM_RAND;
   localparam int WD_CYCLES = NUM_TESTS * 200 + 500;

   logic clk, rst, in_req, in_ack, out_req, out_ack;
   logic [WIDTH-1:0] in_data, out_data;
   logic ref_push, ref_has, quiet, stall, report;
   logic [WIDTH-1:0] ref_sum;
   int checked, errors, issued, ack_delay;
   bit hold;
   logic [31:0] lfsr;

   // Directed table of eight words, expected sum, name and ack delay
   logic [WIDTH-1:0] tbl_w [NUM_ROWS][8];
   logic [WIDTH-1:0] tbl_exp [NUM_ROWS];
   string tbl_name [NUM_ROWS];
   int tbl_dly [NUM_ROWS];
   int nrows;

   dot_product_top #(.WIDTH(WIDTH), .DEPTH(DEPTH)) dut0 (.*);

   dot_product_monitor #(.WIDTH(WIDTH)) mon0 (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      repeat (WD_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   // Galois LFSR stepped once per bit taken
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         r    = {r[14:0], lfsr[0]};
      end
      return r;
   endfunction

   // Words packed a0 first in the top bits
   task automatic add_row(input string name, input int dly, input logic [WIDTH-1:0] exp,
                          input logic [8*WIDTH-1:0] pk);
      for (int i = 0; i < 8; i++) begin
         tbl_w[nrows][i] = pk[8*WIDTH-1-WIDTH*i -: WIDTH];
      end
      tbl_exp[nrows]  = exp;
      tbl_name[nrows] = name;
      tbl_dly[nrows]  = dly;
      nrows++;
   endtask

   task automatic push_ref(input logic has, input logic [WIDTH-1:0] s);
      @(posedge clk);
      ref_push <= 1'b1;
      ref_has  <= has;
      ref_sum  <= s;
      @(posedge clk);
      ref_push <= 1'b0;
   endtask

   // One full four-phase transfer on the input channel
   task automatic send_word(input logic [WIDTH-1:0] w, input int gap);
      repeat (gap) @(posedge clk);
      @(posedge clk);
      in_req  <= 1'b1;
      in_data <= w;
      do @(posedge clk); while (!in_ack);
      in_req <= 1'b0;
      do @(posedge clk); while (in_ack);
   endtask

   task automatic wait_results(input int n);
      while (checked < n) @(posedge clk);
   endtask

   // Host receiver acks each result after ack_delay cycles unless held
   initial begin
      out_ack = 1'b0;
      forever begin
         @(posedge clk);
         if (out_ack) begin
            if (!out_req) out_ack <= 1'b0;
         end else if (out_req && !hold) begin
            repeat (ack_delay) @(posedge clk);
            out_ack <= 1'b1;
         end
      end
   end

   initial begin
      in_req    = 1'b0;
      in_data   = '0;
      rst       = 1'b1;
      ref_push  = 1'b0;
      ref_has   = 1'b0;
      ref_sum   = '0;
      quiet     = 1'b0;
      stall     = 1'b0;
      report    = 1'b0;
      hold      = 1'b0;
      ack_delay = 0;
      issued    = 0;
      nrows     = 0;
      lfsr      = 32'h6f60;
      add_row("all zero", 0, 16'h0000, '0);
      add_row("unit", 1, 16'h0001, {16'd1, 16'd1, {6{16'd0}}});
      add_row("single pair", 2, 16'd63, {{4{16'd0}}, 16'd7, 16'd9, {2{16'd0}}});
      add_row("all ones", 0, 16'd4, {8{16'd1}});
      add_row("mixed", 3, 16'd140, {16'd2, 16'd3, 16'd4, 16'd5, 16'd6, 16'd7, 16'd8, 16'd9});
      add_row("max operands", 1, 16'd4, {8{16'hffff}});
      add_row("sum wrap", 0, 16'h0000, {4{16'h8000, 16'h0001}});
      add_row("product wrap", 2, 16'd15,
              {16'h0100, 16'h0100, 16'd3, 16'd5, {4{16'd0}}});
      repeat (2) @(posedge clk);
      rst <= 1'b0;

      // Idle host with both channels quiet
      quiet <= 1'b1;
      repeat (20) @(posedge clk);
      quiet <= 1'b0;
      $display("idle check done");

      // ======================================================================
      // Directed table
      // ======================================================================
      for (int r = 0; r < nrows; r++) begin
         $display("running %s", tbl_name[r]);
         ack_delay = tbl_dly[r];
         push_ref(1'b1, tbl_exp[r]);
         for (int i = 0; i < 8; i++) send_word(tbl_w[r][i], 0);
         issued++;
         wait_results(issued);
      end

      // ======================================================================
      // Back-pressure with DEPTH stored vectors and a stalled eighth word
      // ======================================================================
      $display("running back-pressure");
      hold <= 1'b1;
      ack_delay = 0;
      for (int k = 0; k <= DEPTH; k++) begin
         push_ref(1'b1, WIDTH'(2 * (k + 1)));
         send_word(WIDTH'(k + 1), 0);
         send_word(16'd2, 0);
         for (int i = 2; i < 7; i++) send_word('0, 0);
         if (k < DEPTH) send_word('0, 0);
      end
      @(posedge clk);
      in_req  <= 1'b1;
      in_data <= '0;
      stall   <= 1'b1;
      repeat (20) @(posedge clk);
      stall <= 1'b0;
      hold  <= 1'b0;
      do @(posedge clk); while (!in_ack);
      in_req <= 1'b0;
      do @(posedge clk); while (in_ack);
      issued += DEPTH + 1;
      wait_results(issued);

      // Random vectors with random host pacing
      for (int t = 0; t < NUM_RAND; t++) begin
         ack_delay = int'(rand_bits(2));
         push_ref(1'b0, '0);
         for (int i = 0; i < 8; i++) send_word(rand_bits(WIDTH), int'(rand_bits(2)));
         issued++;
         wait_results(issued);
      end

      @(posedge clk);
      report <= 1'b1;
      @(posedge clk);
      report <= 1'b0;
      @(posedge clk);
      if (errors == 0 && checked == issued) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
